//--- lsu_read_unit.f
+incdir+src
src/lsu_pkg.sv
src/lsu_rd_stage_router.sv
src/lsu_rd_stage.sv
src/vgpr_bank.sv
src/sgpr_bank.sv
src/lsu_read_unit.sv
verification/lsu_read_unit_asserts.sv
verification/tb_lsu_read_unit.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the LSU operand-read testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f lsu_read_unit.f \
   --top-module tb_lsu_read_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

out=$(./obj_dir/Vtb_lsu_read_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
   exit 0
fi
exit 1

//--- verification/tb_lsu_read_unit.sv
`timescale 1ns/1ns

`include "lsu_macros.svh"

module tb_lsu_read_unit;

   import lsu_pkg::*;

   logic clk;
   logic rst_n;
   lsu_instr_t instr;
   lsu_instr_t prev_instr;   // instruction the DUT delivers this cycle
   logic vgpr_wr_en;
   logic [9:0] vgpr_wr_addr;
   logic [127:0] vgpr_wr_data;
   logic sgpr_wr_en;
   logic [8:0] sgpr_wr_addr;
   logic [31:0] sgpr_wr_data;
   logic [511:0] vector_source_a;
   logic [127:0] vector_source_b;
   logic [127:0] scalar_source_a;
   logic [31:0] scalar_source_b;
   lsu_mem_ctl_t mem_ctl;

   logic [127:0] vmem [0:1023];   // reference copies of the banks
   logic [31:0] smem [0:511];
   logic [15:0] legal_ops [0:8];
   logic [511:0] exp_va;
   logic [127:0] exp_vb;
   logic [127:0] exp_sa;
   logic [31:0] exp_sb;
   lsu_mem_ctl_t exp_ctl;
   integer seed;
   int errors;
   int checks;
   int cycles;

   lsu_read_unit uut (
      .clk             (clk),
      .rst_n           (rst_n),
      .instr           (instr),
      .vgpr_wr_en      (vgpr_wr_en),
      .vgpr_wr_addr    (vgpr_wr_addr),
      .vgpr_wr_data    (vgpr_wr_data),
      .sgpr_wr_en      (sgpr_wr_en),
      .sgpr_wr_addr    (sgpr_wr_addr),
      .sgpr_wr_data    (sgpr_wr_data),
      .vector_source_a (vector_source_a),
      .vector_source_b (vector_source_b),
      .scalar_source_a (scalar_source_a),
      .scalar_source_b (scalar_source_b),
      .mem_ctl         (mem_ctl)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= 2000)   // 1536 preload plus ~300 instructions plus reset
      begin
         $display("timeout: run did not finish within %0d cycles", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   always @(posedge clk)
   begin
      prev_instr <= rst_n ? instr : '0;
   end

   task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // expected outputs from the format and opcode rules
   task automatic predict(input lsu_instr_t x);
      logic [9:0] v1;
      logic [9:0] v2;
      logic [8:0] s1;
      logic [8:0] s2;
      v1 = '0;
      v2 = '0;
      s1 = '0;
      s2 = '0;
      exp_va = '0;
      exp_vb = '0;
      exp_sa = '0;
      exp_sb = '0;
      exp_ctl = '0;
      if (x.select)
      begin
         if (x.opcode[31:24] == `LSU_SMRD_FORMAT)
         begin
            s1 = x.source_reg2.sgpr.addr;
            s2 = x.source_reg1.sgpr.addr;
         end
         else if (x.opcode[31:24] == `LSU_DS_FORMAT)
         begin
            v1 = x.source_reg2.vgpr.addr;
            v2 = x.source_reg1.vgpr.addr;
         end
         else if (x.opcode[31:24] == `LSU_MTBUF_FORMAT)
         begin
            v1 = x.source_reg2.vgpr.addr;
            v2 = x.source_reg3.vgpr.addr;
            s1 = x.mem_sgpr.sgpr.addr;
            s2 = x.source_reg1.sgpr.addr;
         end
         for (int k = 0; k < 4; k++)
         begin
            exp_va[k*128 +: 128] = vmem[v1 + 10'(k)];   // wraps at 1024
            exp_sa[k*32 +: 32] = smem[s1 + 9'(k)];
         end
         exp_vb = vmem[v2];
         exp_sb = smem[s2];
         case ({x.opcode[31:24], x.opcode[7:0]})
            {`LSU_SMRD_FORMAT, `LSU_OP_S_BUFFER_LOAD_DWORD},
            {`LSU_DS_FORMAT, `LSU_OP_DS_READ_B32},
            {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_LOAD_X}:
               exp_ctl = '{rd_en: 4'b0001, wr_en: 4'b0, lddst_stsrc_addr: x.dest_reg,
                           illegal_op: 1'b0};
            {`LSU_SMRD_FORMAT, `LSU_OP_S_BUFFER_LOAD_DWORDX2}:
               exp_ctl = '{rd_en: 4'b0011, wr_en: 4'b0, lddst_stsrc_addr: x.dest_reg,
                           illegal_op: 1'b0};
            {`LSU_SMRD_FORMAT, `LSU_OP_S_LOAD_DWORDX4},
            {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_LOAD_XYZW}:
               exp_ctl = '{rd_en: 4'b1111, wr_en: 4'b0, lddst_stsrc_addr: x.dest_reg,
                           illegal_op: 1'b0};
            {`LSU_DS_FORMAT, `LSU_OP_DS_WRITE_B32},
            {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_STORE_X}:
               exp_ctl = '{rd_en: 4'b0, wr_en: 4'b0001, lddst_stsrc_addr: x.source_reg2,
                           illegal_op: 1'b0};
            {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_STORE_XYZW}:
               exp_ctl = '{rd_en: 4'b0, wr_en: 4'b1111, lddst_stsrc_addr: x.source_reg2,
                           illegal_op: 1'b0};
            default:
               exp_ctl.illegal_op = 1'b1;
         endcase
      end
   endtask

   always @(negedge clk)
   begin
      if (rst_n)
      begin
         predict(prev_instr);
         check("vector_source_a", vector_source_a, exp_va);
         check("vector_source_b", 512'(vector_source_b), 512'(exp_vb));
         check("scalar_source_a", 512'(scalar_source_a), 512'(exp_sa));
         check("scalar_source_b", 512'(scalar_source_b), 512'(exp_sb));
         check("mem_ctl.rd_en", 512'(mem_ctl.rd_en), 512'(exp_ctl.rd_en));
         check("mem_ctl.wr_en", 512'(mem_ctl.wr_en), 512'(exp_ctl.wr_en));
         check("mem_ctl.lddst_stsrc_addr", 512'(mem_ctl.lddst_stsrc_addr),
               512'(exp_ctl.lddst_stsrc_addr));
         check("mem_ctl.illegal_op", 512'(mem_ctl.illegal_op), 512'(exp_ctl.illegal_op));
      end
   end

   task automatic make_instr(input logic [7:0] fmt, input logic [7:0] op,
                             output lsu_instr_t x);
      logic [31:0] r;
      r = $random(seed);
      x.select = 1'b1;
      x.opcode = {fmt, r[15:0], op};
      r = $random(seed);
      x.source_reg1 = r[11:0];
      x.source_reg2 = r[23:12];
      r = $random(seed);
      x.source_reg3 = r[11:0];
      x.mem_sgpr = r[23:12];
      r = $random(seed);
      x.dest_reg = r[11:0];
   endtask

   task automatic issue(input lsu_instr_t x);
      @(posedge clk);
      instr <= x;
   endtask

   task automatic preload_banks();
      logic [31:0] r;
      logic [127:0] entry;
      for (int i = 0; i < 1024; i++)
      begin
         for (int l = 0; l < 4; l++)
         begin
            r = $random(seed);
            entry[l*32 +: 32] = {i[9:0], l[1:0], r[19:0]};   // address in every lane
         end
         vmem[i] = entry;
         @(posedge clk);
         vgpr_wr_en <= 1'b1;
         vgpr_wr_addr <= i[9:0];
         vgpr_wr_data <= entry;
      end
      for (int i = 0; i < 512; i++)
      begin
         r = $random(seed);
         smem[i] = {i[8:0], r[22:0]};
         @(posedge clk);
         vgpr_wr_en <= 1'b0;
         sgpr_wr_en <= 1'b1;
         sgpr_wr_addr <= i[8:0];
         sgpr_wr_data <= {i[8:0], r[22:0]};
      end
      @(posedge clk);
      sgpr_wr_en <= 1'b0;
   endtask

   initial
   begin
      lsu_instr_t x;
      logic [31:0] r;
      seed = 32'h81cd_dec1;
      errors = 0;
      checks = 0;
      cycles = 0;
      rst_n = 1'b0;
      instr = '0;
      vgpr_wr_en = 1'b0;
      vgpr_wr_addr = '0;
      vgpr_wr_data = '0;
      sgpr_wr_en = 1'b0;
      sgpr_wr_addr = '0;
      sgpr_wr_data = '0;
      legal_ops = '{{`LSU_SMRD_FORMAT, `LSU_OP_S_BUFFER_LOAD_DWORD},
                    {`LSU_SMRD_FORMAT, `LSU_OP_S_BUFFER_LOAD_DWORDX2},
                    {`LSU_SMRD_FORMAT, `LSU_OP_S_LOAD_DWORDX4},
                    {`LSU_DS_FORMAT, `LSU_OP_DS_READ_B32},
                    {`LSU_DS_FORMAT, `LSU_OP_DS_WRITE_B32},
                    {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_LOAD_X},
                    {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_LOAD_XYZW},
                    {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_STORE_X},
                    {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_STORE_XYZW}};
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      preload_banks();
      for (int j = 0; j < 9; j++)   // each legal op, then idle
      begin
         make_instr(legal_ops[j][15:8], legal_ops[j][7:0], x);
         issue(x);
         issue('0);
      end
      make_instr(`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_LOAD_XYZW, x);
      x.source_reg2.vgpr.addr = 10'd1022;   // burst wraps past the bank top
      x.mem_sgpr.sgpr.addr = 9'd510;
      issue(x);
      make_instr(8'h08, `LSU_OP_S_BUFFER_LOAD_DWORD, x);   // unknown format
      issue(x);
      make_instr(`LSU_SMRD_FORMAT, `LSU_OP_DS_READ_B32, x);   // opcode of another format
      issue(x);
      for (int n = 0; n < 28; n++)
      begin
         for (int j = 0; j < 9; j++)
         begin
            make_instr(legal_ops[j][15:8], legal_ops[j][7:0], x);
            issue(x);
         end
         r = $random(seed);
         make_instr(r[31:24], r[7:0], x);
         issue(x);
         if (r[8])
         begin
            issue('0);
         end
      end
      issue('0);
      repeat (2) @(posedge clk);
      @(negedge clk);
      #1;
      $display("errors: %0d, checks: %0d", errors, checks);
      if (errors == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- verification/lsu_read_unit_asserts.sv
`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_read_unit_asserts (
   input logic                                              clk,
   input logic                                              rst_n,
   input lsu_pkg::lsu_instr_t                               instr,
   input logic [`LSU_BURST_LEN*`LSU_LANES*`LSU_DWORD_W-1:0] vector_source_a,
   input logic [`LSU_LANES*`LSU_DWORD_W-1:0]                vector_source_b,
   input logic [`LSU_BURST_LEN*`LSU_DWORD_W-1:0]            scalar_source_a,
   input logic [`LSU_DWORD_W-1:0]                           scalar_source_b,
   input lsu_pkg::lsu_mem_ctl_t                             mem_ctl
);

   logic select_q;   // mirrors the stage's flopped select

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         select_q <= 1'b0;
      end
      else
      begin
         select_q <= instr.select;
      end
   end

   a_illegal_no_enables: assert property (@(posedge clk) disable iff (!rst_n)
      mem_ctl.illegal_op |-> (mem_ctl.rd_en == 4'b0 && mem_ctl.wr_en == 4'b0))
      else $error("illegal_op raised together with a nonzero enable");

   a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !((|mem_ctl.rd_en) && (|mem_ctl.wr_en)))
      else $error("rd_en and wr_en both nonzero");

   a_idle_outputs_zero: assert property (@(posedge clk) disable iff (!rst_n)
      !select_q |-> (mem_ctl == '0 && vector_source_a == '0 && vector_source_b == '0
                     && scalar_source_a == '0 && scalar_source_b == '0))
      else $error("outputs not zero while the flopped select is low");

endmodule

bind lsu_read_unit lsu_read_unit_asserts u_asserts (
   .clk             (clk),
   .rst_n           (rst_n),
   .instr           (instr),
   .vector_source_a (vector_source_a),
   .vector_source_b (vector_source_b),
   .scalar_source_a (scalar_source_a),
   .scalar_source_b (scalar_source_b),
   .mem_ctl         (mem_ctl)
);

//--- src/lsu_read_unit.sv
`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_read_unit (
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  lsu_pkg::lsu_instr_t                               instr,
   input  logic                                              vgpr_wr_en,
   input  logic [$clog2(`LSU_VGPR_DEPTH)-1:0]                vgpr_wr_addr,
   input  logic [`LSU_LANES*`LSU_DWORD_W-1:0]                vgpr_wr_data,
   input  logic                                              sgpr_wr_en,
   input  logic [$clog2(`LSU_SGPR_DEPTH)-1:0]                sgpr_wr_addr,
   input  logic [`LSU_DWORD_W-1:0]                           sgpr_wr_data,
   output logic [`LSU_BURST_LEN*`LSU_LANES*`LSU_DWORD_W-1:0] vector_source_a,
   output logic [`LSU_LANES*`LSU_DWORD_W-1:0]                vector_source_b,
   output logic [`LSU_BURST_LEN*`LSU_DWORD_W-1:0]            scalar_source_a,
   output logic [`LSU_DWORD_W-1:0]                           scalar_source_b,
   output lsu_pkg::lsu_mem_ctl_t                             mem_ctl
);

   import lsu_pkg::*;

   lsu_rd_addr_t rd_addr;

   lsu_rd_stage u_rd_stage (
      .clk     (clk),
      .rst_n   (rst_n),
      .instr   (instr),
      .rd_addr (rd_addr),
      .mem_ctl (mem_ctl)
   );

   vgpr_bank u_vgpr_bank (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr_en        (vgpr_wr_en),
      .wr_addr      (vgpr_wr_addr),
      .wr_data      (vgpr_wr_data),
      .rd_addr      (rd_addr),
      .source1_data (vector_source_a),
      .source2_data (vector_source_b)
   );

   sgpr_bank u_sgpr_bank (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr_en        (sgpr_wr_en),
      .wr_addr      (sgpr_wr_addr),
      .wr_data      (sgpr_wr_data),
      .rd_addr      (rd_addr),
      .source1_data (scalar_source_a),
      .source2_data (scalar_source_b)
   );

endmodule

//--- src/sgpr_bank.sv
`timescale 1ns/1ns

`include "lsu_macros.svh"

module sgpr_bank #(
   parameter int ADDR_W = $clog2(`LSU_SGPR_DEPTH)
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 wr_en,
   input  logic [ADDR_W-1:0]                    wr_addr,
   input  logic [`LSU_DWORD_W-1:0]              wr_data,
   input  lsu_pkg::lsu_rd_addr_t                rd_addr,
   output logic [`LSU_BURST_LEN*`LSU_DWORD_W-1:0] source1_data,
   output logic [`LSU_DWORD_W-1:0]              source2_data
);

   logic [`LSU_DWORD_W-1:0] mem [0:`LSU_SGPR_DEPTH-1];
   logic [ADDR_W-1:0]       burst_addr [0:`LSU_BURST_LEN-1];

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   for (genvar k = 0; k < `LSU_BURST_LEN; k++)
   begin : g_burst
      assign burst_addr[k] = rd_addr.sgpr1 + ADDR_W'(k);
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || !rd_addr.rd_en)
      begin
         source1_data <= '0;
         source2_data <= '0;
      end
      else
      begin
         for (int k = 0; k < `LSU_BURST_LEN; k++)
         begin
            source1_data[k*`LSU_DWORD_W +: `LSU_DWORD_W] <= mem[burst_addr[k]];   // word k in slice k
         end
         source2_data <= mem[rd_addr.sgpr2];
      end
   end

endmodule

//--- src/vgpr_bank.sv
`timescale 1ns/1ns

`include "lsu_macros.svh"

module vgpr_bank #(
   parameter int ADDR_W  = $clog2(`LSU_VGPR_DEPTH),
   parameter int ENTRY_W = `LSU_LANES * `LSU_DWORD_W
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           wr_en,
   input  logic [ADDR_W-1:0]              wr_addr,
   input  logic [ENTRY_W-1:0]             wr_data,
   input  lsu_pkg::lsu_rd_addr_t          rd_addr,
   output logic [`LSU_BURST_LEN*ENTRY_W-1:0] source1_data,
   output logic [ENTRY_W-1:0]             source2_data
);

   logic [ENTRY_W-1:0] mem [0:`LSU_VGPR_DEPTH-1];
   logic [ADDR_W-1:0]  burst_addr [0:`LSU_BURST_LEN-1];

   // preload port
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   for (genvar k = 0; k < `LSU_BURST_LEN; k++)
   begin : g_burst
      assign burst_addr[k] = rd_addr.vgpr1 + ADDR_W'(k);   // wraps at bank top
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n || !rd_addr.rd_en)
      begin
         source1_data <= '0;
         source2_data <= '0;
      end
      else
      begin
         for (int k = 0; k < `LSU_BURST_LEN; k++)
         begin
            source1_data[k*ENTRY_W +: ENTRY_W] <= mem[burst_addr[k]];
         end
         source2_data <= mem[rd_addr.vgpr2];
      end
   end

endmodule

//--- src/lsu_rd_stage.sv
`timescale 1ns/1ns

module lsu_rd_stage (
   input  logic                  clk,
   input  logic                  rst_n,
   input  lsu_pkg::lsu_instr_t   instr,
   output lsu_pkg::lsu_rd_addr_t rd_addr,
   output lsu_pkg::lsu_mem_ctl_t mem_ctl
);

   import lsu_pkg::*;

   lsu_instr_t instr_flopped;

   // aligns the decoded controls with the registered bank data
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         instr_flopped <= '0;
      end
      else
      begin
         instr_flopped <= instr;
      end
   end

   lsu_rd_stage_router u_router (
      .instr         (instr),
      .instr_flopped (instr_flopped),
      .rd_addr       (rd_addr),
      .mem_ctl       (mem_ctl)
   );

endmodule

//--- src/lsu_rd_stage_router.sv
`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_rd_stage_router (
   input  lsu_pkg::lsu_instr_t   instr,
   input  lsu_pkg::lsu_instr_t   instr_flopped,
   output lsu_pkg::lsu_rd_addr_t rd_addr,
   output lsu_pkg::lsu_mem_ctl_t mem_ctl
);

   // register read addresses, from the instruction being issued
   always_comb
   begin
      rd_addr       = '0;
      rd_addr.rd_en = instr.select;
      case (instr.opcode[31:24])
         `LSU_SMRD_FORMAT:
         begin
            rd_addr.sgpr1 = instr.source_reg2.sgpr.addr;   // sbase
            rd_addr.sgpr2 = instr.source_reg1.sgpr.addr;   // offset
         end
         `LSU_DS_FORMAT:
         begin
            rd_addr.vgpr1 = instr.source_reg2.vgpr.addr;   // data0
            rd_addr.vgpr2 = instr.source_reg1.vgpr.addr;   // addr
         end
         `LSU_MTBUF_FORMAT:
         begin
            rd_addr.vgpr1 = instr.source_reg2.vgpr.addr;   // vdata
            rd_addr.vgpr2 = instr.source_reg3.vgpr.addr;   // vaddr
            rd_addr.sgpr1 = instr.mem_sgpr.sgpr.addr;      // srsrc
            rd_addr.sgpr2 = instr.source_reg1.sgpr.addr;   // soffset
         end
         default:
         begin
            rd_addr.vgpr1 = '0;
            rd_addr.vgpr2 = '0;
            rd_addr.sgpr1 = '0;
            rd_addr.sgpr2 = '0;
         end
      endcase
   end

   // dword enables and ld/st register, one cycle behind the read addresses
   always_comb
   begin
      mem_ctl = '0;
      if (instr_flopped.select)
      begin
         case ({instr_flopped.opcode[31:24], instr_flopped.opcode[7:0]})
            {`LSU_SMRD_FORMAT, `LSU_OP_S_BUFFER_LOAD_DWORD}:
            begin
               mem_ctl.rd_en            = 4'b0001;
               mem_ctl.lddst_stsrc_addr = instr_flopped.dest_reg;
            end
            {`LSU_SMRD_FORMAT, `LSU_OP_S_BUFFER_LOAD_DWORDX2}:
            begin
               mem_ctl.rd_en            = 4'b0011;
               mem_ctl.lddst_stsrc_addr = instr_flopped.dest_reg;
            end
            {`LSU_SMRD_FORMAT, `LSU_OP_S_LOAD_DWORDX4}:
            begin
               mem_ctl.rd_en            = 4'b1111;
               mem_ctl.lddst_stsrc_addr = instr_flopped.dest_reg;
            end
            {`LSU_DS_FORMAT, `LSU_OP_DS_READ_B32}:
            begin
               mem_ctl.rd_en            = 4'b0001;
               mem_ctl.lddst_stsrc_addr = instr_flopped.dest_reg;
            end
            {`LSU_DS_FORMAT, `LSU_OP_DS_WRITE_B32}:
            begin
               mem_ctl.wr_en            = 4'b0001;
               mem_ctl.lddst_stsrc_addr = instr_flopped.source_reg2;   // store data reg
            end
            {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_LOAD_X}:
            begin
               mem_ctl.rd_en            = 4'b0001;
               mem_ctl.lddst_stsrc_addr = instr_flopped.dest_reg;
            end
            {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_LOAD_XYZW}:
            begin
               mem_ctl.rd_en            = 4'b1111;
               mem_ctl.lddst_stsrc_addr = instr_flopped.dest_reg;
            end
            {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_STORE_X}:
            begin
               mem_ctl.wr_en            = 4'b0001;
               mem_ctl.lddst_stsrc_addr = instr_flopped.source_reg2;
            end
            {`LSU_MTBUF_FORMAT, `LSU_OP_TBUFFER_STORE_XYZW}:
            begin
               mem_ctl.wr_en            = 4'b1111;
               mem_ctl.lddst_stsrc_addr = instr_flopped.source_reg2;
            end
            default:
            begin
               mem_ctl.illegal_op = 1'b1;   // enables and reg stay zero
            end
         endcase
      end
   end

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

   // vector register operand, 10-bit address
   typedef struct packed {
      logic [1:0] tag;
      logic [9:0] addr;
   } lsu_vgpr_view_t;

   // scalar register operand, 9-bit address
   typedef struct packed {
      logic [2:0] tag;
      logic [8:0] addr;
   } lsu_sgpr_view_t;

   // one operand field, read as vgpr or sgpr depending on format
   typedef union packed {
      lsu_vgpr_view_t vgpr;
      lsu_sgpr_view_t sgpr;
   } lsu_operand_u;

   typedef struct packed {
      logic         select;
      logic [31:0]  opcode;
      lsu_operand_u source_reg1;
      lsu_operand_u source_reg2;
      lsu_operand_u source_reg3;
      lsu_operand_u mem_sgpr;
      logic [11:0]  dest_reg;
   } lsu_instr_t;

   typedef struct packed {
      logic [9:0] vgpr1;
      logic [9:0] vgpr2;
      logic [8:0] sgpr1;
      logic [8:0] sgpr2;
      logic       rd_en;   // shared by all four read ports
   } lsu_rd_addr_t;

   typedef struct packed {
      logic [3:0]  rd_en;
      logic [3:0]  wr_en;
      logic [11:0] lddst_stsrc_addr;
      logic        illegal_op;
   } lsu_mem_ctl_t;

endpackage

//--- src/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// instruction format codes, opcode[31:24]
`define LSU_SMRD_FORMAT            8'h01
`define LSU_DS_FORMAT              8'h02
`define LSU_MTBUF_FORMAT           8'h04

// SMRD operations, opcode[7:0]
`define LSU_OP_S_BUFFER_LOAD_DWORD   8'h08
`define LSU_OP_S_BUFFER_LOAD_DWORDX2 8'h09
`define LSU_OP_S_LOAD_DWORDX4        8'h02

// DS operations
`define LSU_OP_DS_READ_B32           8'h36
`define LSU_OP_DS_WRITE_B32          8'h0D

// MTBUF operations
`define LSU_OP_TBUFFER_LOAD_X        8'h00
`define LSU_OP_TBUFFER_LOAD_XYZW     8'h03
`define LSU_OP_TBUFFER_STORE_X       8'h04
`define LSU_OP_TBUFFER_STORE_XYZW    8'h07

// datapath sizing
`define LSU_LANES                    4
`define LSU_DWORD_W                  32
`define LSU_BURST_LEN                4

// register bank depths
`define LSU_VGPR_DEPTH               1024
`define LSU_SGPR_DEPTH               512

`endif
